//--- Bender.yml
package:
  name: char_layer

sources:
  # packages ahead of the modules that import them
  - verilog/tile_pkg.sv
  - verilog/bus_pkg.sv
  - verilog/video_timing.sv
  - verilog/tilemap_ram.sv
  - verilog/char_rom.sv
  - verilog/char_render.sv
  - verilog/char_layer.sv
  - target: test
    files:
      - verification/char_layer_tb.sv

//--- char_layer.f
verilog/tile_pkg.sv
verilog/bus_pkg.sv
verilog/video_timing.sv
verilog/tilemap_ram.sv
verilog/char_rom.sv
verilog/char_render.sv
verilog/char_layer.sv
verification/char_layer_tb.sv

//--- verification/char_layer_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the character layer, wishbone tasks,
// lfsr stimulus, pixel reference model and compare process
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module char_layer_tb;

    import tile_pkg::*;
    import bus_pkg::*;

    localparam int h_total     = 320;
    localparam int v_total     = 40;
    localparam int cen_div     = 2;
    localparam int clk_period  = 40;
    localparam int frames_used = 6;  // waits plus two compared frames
    localparam int timeout_ns  =
        (frames_used * h_total * v_total * cen_div + 4000) * clk_period;

    logic clk, rst, wb_cyc, wb_stb, wb_we, wb_ack, pxl_cen;
    logic [wb_aw-1:0]    wb_adr;
    logic [wb_dw-1:0]    wb_dat_w, wb_dat_r;
    logic [wb_sel_w-1:0] wb_sel;
    logic [pxl_w-1:0]    pxl;
    logic [8:0]          hdump, vdump;

    logic [wb_dw-1:0] model_map [0:2**wb_aw-1];  // expected tilemap contents
    logic [31:0]      lfsr   = 32'hc01c;
    logic             cmp_on = 1'b0;             // compare process armed
    int               n_cmp  = 0;
    int               n_clk  = 0;                // rising edges since reset release
    int               pix_idx;                   // pixel enables seen before this cycle

    char_layer #(.cen_div(cen_div), .h_total(h_total), .v_total(v_total)) dut0 (
        .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack), .pxl(pxl), .pxl_cen(pxl_cen), .hdump(hdump), .vdump(vdump)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};  // one step per bit
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // graphics row for code c and row r as planes 2 1 0
    function automatic logic [23:0] gfx_row(input logic [7:0] c, input logic [2:0] r);
        logic [7:0] p0, p1, p2;
        p0 = c ^ 8'(r * 17);
        p1 = c + 8'(r);
        for (int i = 0; i < 8; i++)
            p2[(i + r) % 8] = ~c[i];  // inverted rotate left
        return {p2, p1, p0};
    endfunction

    function automatic logic [pxl_w-1:0] expect_pxl(input logic [8:0] x, input logic [8:0] y);
        logic [15:0] ent;
        logic [23:0] g;
        int          b;
        ent = model_map[{y[7:3], x[8:3]}];  // tile row then tile column
        g   = gfx_row(ent[7:0], y[2:0]);
        b   = 7 - x[2:0];                   // leftmost pixel is the msb
        return {ent[11:8], g[16+b], g[8+b], g[b]};
    endfunction

    // ack must come one clock after stb and last one clock
    task automatic finish_access();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 16)
                abort_run("no wishbone ack within 16 clocks");
        end while (!wb_ack);
        check_eq(waited, 1, "ack latency");
        {wb_cyc, wb_stb, wb_we} = 3'b000;
        @(posedge clk);
        #1;
        check_eq(wb_ack, 0, "ack longer than one cycle");
    endtask

    task automatic wb_write(input logic [wb_aw-1:0] adr, input logic [wb_dw-1:0] dat,
                            input logic [wb_sel_w-1:0] sel);
        {wb_cyc, wb_stb, wb_we} = 3'b111;
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_sel   = sel;
        finish_access();
        for (int i = 0; i < wb_sel_w; i++)
            if (sel[i])
                model_map[adr][i*8 +: 8] = dat[i*8 +: 8];  // only selected lanes
    endtask

    task automatic wb_read(input logic [wb_aw-1:0] adr, output logic [wb_dw-1:0] dat);
        {wb_cyc, wb_stb, wb_we} = 3'b110;
        wb_adr = adr;
        finish_access();
        dat = wb_dat_r;  // holds until the next access
    endtask

    task automatic wait_line(input int line);
        do begin
            @(posedge clk);
            #1;
        end while (vdump != 9'(line));
    endtask

    // one full frame of active pixels through the compare process
    task automatic check_frame();
        wait_line(v_total - 1);
        wait_line(0);
        n_cmp  = 0;
        cmp_on = 1'b1;
        wait_line(32);
        cmp_on = 1'b0;
        check_eq(n_cmp, 32 * (h_total - render_lag), "pixels compared in frame");
    endtask

    always @(negedge clk) begin
        if (cmp_on && pxl_cen && hdump >= 9'(render_lag) && vdump < 9'd32) begin
            check_eq(pxl, expect_pxl(hdump - 9'(render_lag), vdump),
                     $sformatf("pixel x=%0d y=%0d", hdump - 9'(render_lag), vdump));
            n_cmp++;
        end
    end

    always @(posedge clk) begin
        if (!rst)
            n_clk++;
    end

    // enable every cen_div clocks, counters step per enable and wrap at the totals
    always @(negedge clk) begin
        if (!rst) begin
            pix_idx = (n_clk == 0) ? 0 : (n_clk - 1) / cen_div;
            check_eq(pxl_cen, n_clk > 0 && n_clk % cen_div == 0, "pixel enable");
            check_eq(hdump, pix_idx % h_total, "hdump");
            check_eq(vdump, (pix_idx / h_total) % v_total, "vdump");
        end
    end

    initial begin
        #(timeout_ns);
        abort_run($sformatf("watchdog expired, run still going after %0d ns", timeout_ns));
    end

    initial begin
        logic [wb_aw-1:0] adrs [$];
        logic [wb_aw-1:0] a;
        logic [wb_dw-1:0] rd;
        rst = 1'b1;
        {wb_cyc, wb_stb, wb_we} = 3'b000;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (4) begin  // hdump still short of the first load
            check_eq(wb_ack, 0, "ack after reset");
            check_eq(pxl, 0, "pixel before first tile load");
            @(posedge clk);
            #1;
        end
        for (int i = 0; i < 16; i++) begin
            a = 11'(take_bits(11));
            wb_write(a, 16'(take_bits(16)), 2'b11);
            adrs.push_back(a);
        end
        foreach (adrs[i]) begin
            wb_read(adrs[i], rd);
            check_eq(rd, model_map[adrs[i]], "full word read back");
        end
        a = 11'h7c5;  // row 31 is off screen
        wb_write(a, 16'(take_bits(16)), 2'b11);
        wb_write(a, 16'(take_bits(16)), 2'b01);
        wb_read(a, rd);
        check_eq(rd, model_map[a], "low lane write");
        wb_write(a, 16'(take_bits(16)), 2'b10);
        wb_read(a, rd);
        check_eq(rd, model_map[a], "high lane write");
        for (int r = 0; r < 4; r++)
            for (int c = 0; c < h_total / 8; c++)
                wb_write(11'(r * 64 + c), {4'h0, 12'(take_bits(12))}, 2'b11);
        check_frame();
        wait_line(20);
        a = 11'(1 * 64 + 17);  // tile row 1 was drawn earlier in this frame
        wb_write(a, model_map[a] ^ 16'h0a5a, 2'b11);
        wb_read(a, rd);
        check_eq(rd, model_map[a], "rewritten tile read back");
        check_frame();
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- verilog/bus_pkg.sv
//////////////////////////////////////////////////////////////////////
// wishbone widths for the cpu side of the tilemap
//////////////////////////////////////////////////////////////////////
package bus_pkg;

    localparam int wb_dw = 16;           // data bus
    // word address, 5-bit row then 6-bit column
    localparam int wb_aw = 11;
    localparam int wb_sel_w = wb_dw / 8; // one select per byte lane

endpackage

//--- verilog/char_layer.sv
//////////////////////////////////////////////////////////////////////
// character tile layer top, timing generator,
// tilemap ram, graphics rom and renderer
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module char_layer #(
    parameter int cen_div = 2,
    parameter int h_total = 320,
    parameter int v_total = 40
) (
    input  logic                          clk,
    input  logic                          rst,
    // wishbone classic slave
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [bus_pkg::wb_aw-1:0]     wb_adr,
    input  logic [bus_pkg::wb_dw-1:0]     wb_dat_w,
    input  logic [bus_pkg::wb_sel_w-1:0]  wb_sel,
    output logic [bus_pkg::wb_dw-1:0]     wb_dat_r,
    output logic                          wb_ack,
    // video out
    output logic [tile_pkg::pxl_w-1:0]    pxl,
    output logic                          pxl_cen,
    output logic [8:0]                    hdump,
    output logic [8:0]                    vdump
);

    import tile_pkg::*;

    tile_entry_t           scan_entry;  // map word under the beam
    logic [gfx_addr_w-1:0] gfx_addr;
    logic [gfx_dw-1:0]     gfx_data;

    video_timing #(
        .cen_div (cen_div),
        .h_total (h_total),
        .v_total (v_total)
    ) u_timing (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .hdump   (hdump),
        .vdump   (vdump)
    );

    // scan address is tile row then tile column
    tilemap_ram u_map (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_sel     (wb_sel),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .scan_adr   ({vdump[7:3], hdump[8:3]}),
        .scan_entry (scan_entry)
    );

    char_rom u_gfx (
        .clk      (clk),
        .gfx_addr (gfx_addr),
        .gfx_data (gfx_data)
    );

    char_render u_render (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .hdump      (hdump),
        .vdump      (vdump),
        .scan_entry (scan_entry),
        .gfx_addr   (gfx_addr),
        .gfx_data   (gfx_data),
        .pxl        (pxl)
    );

endmodule

//--- verilog/char_render.sv
//////////////////////////////////////////////////////////////////////
// character renderer, tile fetch, rom address,
// bitplane shifters and attribute delay
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module char_render (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            pxl_cen,
    input  logic [8:0]                      hdump,
    input  logic [8:0]                      vdump,
    // tilemap scan data, one clock after the address
    input  tile_pkg::tile_entry_t           scan_entry,
    // graphics rom
    output logic [tile_pkg::gfx_addr_w-1:0] gfx_addr,
    input  logic [tile_pkg::gfx_dw-1:0]     gfx_data,
    output logic [tile_pkg::pxl_w-1:0]      pxl      // attr then colour
);

    import tile_pkg::*;

    localparam int pw = gfx_dw / plane_n;  // 8 bits per plane

    logic [code_w-1:0] code;
    logic [attr_w-1:0] attr0;  // attribute of the tile being fetched
    logic [attr_w-1:0] attr;   // attribute of the tile being drawn
    logic [pw-1:0]     pl0;
    logic [pw-1:0]     pl1;
    logic [pw-1:0]     pl2;
    logic              ld;

    // middle of the tile, map entry for this column is ready
    assign ld = pxl_cen && hdump[2:0] == 3'd4;

    // row within the tile comes straight from vdump
    assign gfx_addr = {code, vdump[2:0]};

    // msb of each plane is the leftmost pixel
    assign pxl = {attr, pl2[pw-1], pl1[pw-1], pl0[pw-1]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            code  <= '0;
            attr0 <= '0;
            attr  <= '0;
            pl0   <= '0;
            pl1   <= '0;
            pl2   <= '0;
        end else if (pxl_cen) begin
            if (ld) begin
                // rom data belongs to the code latched one tile ago
                pl2   <= gfx_data[3*pw-1:2*pw];
                pl1   <= gfx_data[2*pw-1:pw];
                pl0   <= gfx_data[pw-1:0];
                code  <= scan_entry.fields.code;  // next tile
                attr0 <= scan_entry.fields.attr;
                attr  <= attr0;                   // one tile late, matches planes
            end else begin
                pl2 <= pl2 << 1;
                pl1 <= pl1 << 1;
                pl0 <= pl0 << 1;
            end
        end
    end

    // planes only take new data at the tile edge, otherwise hold or shift
    a_plane_load: assert property (@(posedge clk) disable iff (rst)
        ({pl2, pl1, pl0} != $past({pl2, pl1, pl0}) &&
         {pl2, pl1, pl0} != $past({pl2 << 1, pl1 << 1, pl0 << 1}))
        |-> $past(pxl_cen && hdump[2:0] == 3'd4));

endmodule

//--- verilog/char_rom.sv
//////////////////////////////////////////////////////////////////////
// character graphics rom, 2048 x 24, registered output,
// contents computed from code and row
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module char_rom (
    input  logic                            clk,
    input  logic [tile_pkg::gfx_addr_w-1:0] gfx_addr,  // code, row
    output logic [tile_pkg::gfx_dw-1:0]     gfx_data   // planes 2, 1, 0
);

    import tile_pkg::*;

    localparam int pw    = gfx_dw / plane_n;     // bits per plane
    localparam int row_w = gfx_addr_w - code_w;  // 3

    logic [gfx_dw-1:0] rom [0:2**gfx_addr_w-1];

    function automatic logic [gfx_dw-1:0] gfx_word(input logic [code_w-1:0] c,
                                                   input logic [row_w-1:0] r);
        logic [pw-1:0]   p0;
        logic [pw-1:0]   p1;
        logic [2*pw-1:0] rot;
        p0  = c ^ pw'(r * 17);
        p1  = c + pw'(r);
        rot = {c, c} << r;                      // rotate left by r
        return {~rot[2*pw-1:pw], p1, p0};
    endfunction

    initial begin
        for (int a = 0; a < 2**gfx_addr_w; a++)
            rom[a] = gfx_word(code_w'(a >> row_w), row_w'(a));
    end

    always_ff @(posedge clk) begin
        gfx_data <= rom[gfx_addr];  // one clock read
    end

endmodule

//--- verilog/tile_pkg.sv
//////////////////////////////////////////////////////////////////////
// tile layer field widths, tilemap entry union,
// graphics rom geometry, pixel width and render lag
//////////////////////////////////////////////////////////////////////
package tile_pkg;

    localparam int entry_w = 16;      // one tilemap word
    localparam int code_w  = 8;       // character code
    localparam int attr_w  = 4;       // attribute, palette and priority
    localparam int plane_n = 3;       // bitplanes per pixel

    // rom address is code then row inside the tile
    localparam int gfx_addr_w = 11;
    localparam int gfx_dw     = 24;   // three 8-bit planes side by side

    localparam int pxl_w = attr_w + plane_n;  // 7

    // pixel enables from counter value to pixel on screen
    localparam int render_lag = 13;

    // decoded view of a tilemap word
    typedef struct packed {
        logic [entry_w-attr_w-code_w-1:0] spare;  // unused high bits
        logic [attr_w-1:0]                attr;
        logic [code_w-1:0]                code;
    } tile_fields_t;

    // bus and ram see raw, renderer looks at fields
    typedef union packed {
        logic [entry_w-1:0] raw;
        tile_fields_t       fields;
    } tile_entry_t;

endpackage

//--- verilog/tilemap_ram.sv
//////////////////////////////////////////////////////////////////////
// dual-port tilemap ram, wishbone classic slave on port a
// with byte lanes, registered scan read on port b
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tilemap_ram (
    input  logic                          clk,
    input  logic                          rst,
    // cpu side
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [bus_pkg::wb_aw-1:0]     wb_adr,
    input  logic [bus_pkg::wb_dw-1:0]     wb_dat_w,
    input  logic [bus_pkg::wb_sel_w-1:0]  wb_sel,
    output logic [bus_pkg::wb_dw-1:0]     wb_dat_r,
    output logic                          wb_ack,
    // video side
    input  logic [bus_pkg::wb_aw-1:0]     scan_adr,
    output tile_pkg::tile_entry_t         scan_entry
);

    import bus_pkg::*;

    logic [wb_dw-1:0] mem [0:2**wb_aw-1];
    logic             access;

    // new access only when the last ack is gone
    assign access = wb_cyc && wb_stb && !wb_ack;

    // ack one clock after stb, single cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            wb_ack <= 1'b0;
        else
            wb_ack <= access;
    end

    // port a, read data lines up with ack
    always_ff @(posedge clk) begin
        if (access) begin
            wb_dat_r <= mem[wb_adr];  // old word on a write
            if (wb_we) begin
                for (int i = 0; i < wb_sel_w; i++) begin
                    if (wb_sel[i])
                        mem[wb_adr][i*8 +: 8] <= wb_dat_w[i*8 +: 8];
                end
            end
        end
    end

    // port b, read only
    always_ff @(posedge clk) begin
        scan_entry.raw <= mem[scan_adr];  // valid one clock later
    end

    // never two acks back to back
    a_ack_single: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack);

    // ack needs a strobe in the cycle before
    a_ack_after_stb: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb));

endmodule

//--- verilog/video_timing.sv
//////////////////////////////////////////////////////////////////////
// pixel enable divider plus horizontal and vertical
// dump counters for the tile layer
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module video_timing #(
    parameter int cen_div = 2,    // clocks per pixel
    parameter int h_total = 320,
    parameter int v_total = 40
) (
    input  logic       clk,
    input  logic       rst,
    output logic       pxl_cen,   // one clock high every cen_div
    output logic [8:0] hdump,
    output logic [8:0] vdump
);

    localparam int div_w = (cen_div > 1) ? $clog2(cen_div) : 1;

    logic [div_w-1:0] div_cnt;
    logic             h_wrap;

    assign h_wrap = hdump == 9'(h_total - 1);

    // divider, pxl_cen registered so it is 0 out of reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            pxl_cen <= 1'b0;
        end else if (div_cnt == div_w'(cen_div - 1)) begin
            div_cnt <= '0;
            pxl_cen <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            pxl_cen <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump <= '0;
            vdump <= '0;
        end else if (pxl_cen) begin
            hdump <= h_wrap ? 9'd0 : hdump + 9'd1;
            if (h_wrap) // next line
                vdump <= (vdump == 9'(v_total - 1)) ? 9'd0 : vdump + 9'd1;
        end
    end

    a_hdump_range: assert property (@(posedge clk) disable iff (rst)
        hdump < 9'(h_total));

endmodule
